//--- adc/adc_capture.sv
`timescale 1ns/100ps
`default_nettype none

module adc_capture (
	input  logic                       clk,
	input  logic                       reset,
	input  logic [1:0]                 i_sdata_a,
	input  logic [1:0]                 i_sdata_b,
	output logic                       o_ad_cs,
	output launcher_pkg::adc_samples_t o_samples,
	output logic                       o_valid
);

	logic ad_shift;
	logic ad_latch;
	logic [launcher_pkg::ADC_CHANNELS-1:0] sdata;  // a0 a1 b0 b1 from bit 0 up
	launcher_pkg::adc_raw_bank_t raw;

	assign sdata = {i_sdata_b, i_sdata_a};

	adc_frame_timer i_frame_timer (
		.clk     (clk),
		.reset   (reset),
		.o_ad_cs (o_ad_cs),
		.o_shift (ad_shift),
		.o_latch (ad_latch)
	);

	// Four converters sample together, one receiver each
	for (genvar ch = 0; ch < launcher_pkg::ADC_CHANNELS; ch++) begin : g_chan
		adc_channel_rx i_channel_rx (
			.clk     (clk),
			.reset   (reset),
			.i_sdata (sdata[ch]),
			.i_shift (ad_shift),
			.i_latch (ad_latch),
			.o_raw   (raw[ch])
		);
	end

	adc_sample_decoder i_sample_decoder (
		.clk       (clk),
		.reset     (reset),
		.i_raw     (raw),
		.i_latch   (ad_latch),
		.o_samples (o_samples),
		.o_valid   (o_valid)
	);

endmodule

`default_nettype wire

//--- adc/adc_channel_rx.sv
`timescale 1ns/100ps
`default_nettype none

module adc_channel_rx (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   i_sdata,  // Serial data from converter
	input  logic                   i_shift,
	input  logic                   i_latch,
	output launcher_pkg::adc_raw_t o_raw     // Held word, stable for a frame
);

	launcher_pkg::adc_raw_t shift_reg;

	// MSB arrives first
	always_ff @(posedge clk) begin
		if (i_shift) begin
			shift_reg <= {shift_reg[launcher_pkg::ADC_BITS-2:0], i_sdata};
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			o_raw <= {1'b0, {(launcher_pkg::ADC_BITS-1){1'b1}}}; // Reads as zero
		end else if (i_latch) begin
			o_raw <= shift_reg;
		end
	end

endmodule

`default_nettype wire

//--- adc/adc_frame_timer.sv
`timescale 1ns/100ps
`default_nettype none

module adc_frame_timer (
	input  logic clk,
	input  logic reset,
	output logic o_ad_cs,  // One cycle per frame, starts conversion
	output logic o_shift,  // Capture enable for the data bits
	output logic o_latch   // Hold register load, once per frame
);

	launcher_pkg::adc_cnt_t count;  // Down counter through the frame
	launcher_pkg::adc_cnt_t phase;  // Frame cycle, 0 at chip select

	// Free running from reset, reloads after zero
	always_ff @(posedge clk) begin
		if (reset) begin
			count <= launcher_pkg::adc_cnt_t'(launcher_pkg::ADC_FRAME_CYCLES - 1);
		end else if (count == '0) begin
			count <= launcher_pkg::adc_cnt_t'(launcher_pkg::ADC_FRAME_CYCLES - 1);
		end else begin
			count <= count - 1'b1;
		end
	end

	assign phase = (count == '0) ? '0 :
		launcher_pkg::adc_cnt_t'(launcher_pkg::ADC_FRAME_CYCLES - int'(count));

	assign o_ad_cs = (count == '0);

	// Strobes lead by one, the capturing edge starts the named frame cycle
	assign o_shift = (phase >= launcher_pkg::adc_cnt_t'(launcher_pkg::ADC_SHIFT_FIRST - 1)) &&
		(phase <= launcher_pkg::adc_cnt_t'(launcher_pkg::ADC_SHIFT_FIRST +
		launcher_pkg::ADC_BITS - 2));
	assign o_latch = (phase == launcher_pkg::adc_cnt_t'(launcher_pkg::ADC_LATCH_CYCLE - 1));

endmodule

`default_nettype wire

//--- adc/adc_sample_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module adc_sample_decoder (
	input  logic                        clk,
	input  logic                        reset,
	input  launcher_pkg::adc_raw_bank_t i_raw,
	input  logic                        i_latch,
	output launcher_pkg::adc_samples_t  o_samples,
	output logic                        o_valid    // One cycle, aligned with new data
);

	logic latch_d;                                           // Hold regs now loaded
	launcher_pkg::adc_raw_bank_t corr;                       // Bias corrected words
	launcher_pkg::adc_mag_t mag [launcher_pkg::ADC_CHANNELS];

	// Offset then clip negatives to zero
	always_comb begin
		for (int ch = 0; ch < launcher_pkg::ADC_CHANNELS; ch++) begin
			corr[ch] = i_raw[ch] + launcher_pkg::ADC_OFFSET[ch];
			mag[ch] = corr[ch][launcher_pkg::ADC_BITS-1] ? '0 :
				~corr[ch][launcher_pkg::ADC_BITS-2:0];
		end
	end

	always_ff @(posedge clk) begin
		if (latch_d) begin
			o_samples.i_out <= mag[0];
			o_samples.v_cap <= mag[1];
			o_samples.v_aux <= mag[2];
			o_samples.v_out <= mag[3];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			latch_d <= 1'b0;
			o_valid <= 1'b0;
		end else begin
			latch_d <= i_latch;
			o_valid <= latch_d;
		end
	end

endmodule

`default_nettype wire

//--- common/launcher_pkg.sv
`default_nettype none

package launcher_pkg;

	//////////////////////////////////////////////////////////////////////
	// ADC frame and word format
	//////////////////////////////////////////////////////////////////////

	localparam int ADC_BITS = 12;          // Bits per converter word
	localparam int ADC_CHANNELS = 4;       // a0 a1 b0 b1
	localparam int ADC_FRAME_CYCLES = 16;  // One 3 MHz frame at 48 MHz
	localparam int ADC_SHIFT_FIRST = 2;    // Frame cycle of the MSB
	localparam int ADC_LATCH_CYCLE = 14;   // Hold registers valid from here
	localparam int ADC_CNT_BITS = $clog2(ADC_FRAME_CYCLES);

	typedef logic [ADC_CNT_BITS-1:0] adc_cnt_t;

	// Offset binary, bit 11 set is negative, else magnitude is low bits inverted
	typedef logic [ADC_BITS-1:0] adc_raw_t;
	typedef logic [ADC_BITS-2:0] adc_mag_t;       // Clipped, always positive
	typedef adc_raw_t [ADC_CHANNELS-1:0] adc_raw_bank_t;

	typedef struct packed {
		adc_mag_t i_out;   // Output current, 205 DN per amp
		adc_mag_t v_cap;   // Storage cap voltage
		adc_mag_t v_aux;
		adc_mag_t v_out;   // Igniter side voltage
	} adc_samples_t;

	// Bias correction, index 0 is i_out
	localparam adc_raw_bank_t ADC_OFFSET = {12'd6, 12'd5, 12'd5, 12'd5};

	//////////////////////////////////////////////////////////////////////
	// Fire button debounce
	//////////////////////////////////////////////////////////////////////

	localparam int DB_PRESS_CYCLES = 50;    // Press qualify time
	localparam int DB_PULSE_CYCLES = 20;    // Length of the fire pulse
	localparam int DB_RELEASE_CYCLES = 100; // Low time before re-arm
	localparam int DB_CNT_BITS = $clog2(DB_RELEASE_CYCLES);

	typedef logic [DB_CNT_BITS-1:0] db_cnt_t;

	typedef enum logic [2:0] {
		DB_IDLE,
		DB_PRESS,
		DB_PULSE,
		DB_HELD,
		DB_RELEASE
	} db_state_t;

	//////////////////////////////////////////////////////////////////////
	// Fire sequence and current regulation
	//////////////////////////////////////////////////////////////////////

	localparam int FIRE_START = 1;     // Window opens
	localparam int FIRE_STEP = 2000;   // Switch to high setpoint
	localparam int FIRE_END = 4000;    // Window closes, dump
	localparam int FIRE_CNT_BITS = $clog2(FIRE_END + 2);

	typedef logic [FIRE_CNT_BITS-1:0] fire_cnt_t;

	localparam adc_mag_t SET_LO_DN = 11'd410;    // 2 A
	localparam adc_mag_t SET_HI_DN = 11'd820;    // 4 A
	localparam adc_mag_t SET_BAND_DN = 11'd20;   // Half band

	localparam int PWM_MIN_ON = 8;
	localparam int PWM_MAX_ON = 48;
	localparam int PWM_MIN_OFF = 12;
	localparam int PWM_CNT_BITS = $clog2(PWM_MAX_ON + 1);

	typedef logic [PWM_CNT_BITS-1:0] pwm_cnt_t;

	localparam adc_mag_t ARM_ON_DN = 11'd1496;   // 300 V
	localparam adc_mag_t ARM_OFF_DN = 11'd249;   // 50 V
	localparam int BLINK_BITS = 6;               // Arm LED blink divider

endpackage

`default_nettype wire

//--- logic/current_regulator.sv
`timescale 1ns/100ps
`default_nettype none

module current_regulator (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   i_firing,    // Window active
	input  logic                   i_high_set,  // 4 A instead of 2 A
	input  launcher_pkg::adc_mag_t i_i_out,     // Measured output current
	output logic                   o_pwm
);

	launcher_pkg::adc_mag_t setpoint;
	launcher_pkg::adc_mag_t thresh_lo;   // Start a pulse below this
	launcher_pkg::adc_mag_t thresh_hi;   // End a pulse above this
	launcher_pkg::pwm_cnt_t on_cnt;      // Cycles high so far, inclusive
	launcher_pkg::pwm_cnt_t off_cnt;     // Cycles low, saturates at min off
	logic min_on_done;
	logic max_on_done;
	logic min_off_done;
	logic start_pulse;
	logic end_pulse;

	assign setpoint = i_high_set ? launcher_pkg::SET_HI_DN : launcher_pkg::SET_LO_DN;
	assign thresh_lo = setpoint - launcher_pkg::SET_BAND_DN;
	assign thresh_hi = setpoint + launcher_pkg::SET_BAND_DN;

	assign min_on_done = (on_cnt >= launcher_pkg::pwm_cnt_t'(launcher_pkg::PWM_MIN_ON));
	assign max_on_done = (on_cnt >= launcher_pkg::pwm_cnt_t'(launcher_pkg::PWM_MAX_ON));
	assign min_off_done = (off_cnt >= launcher_pkg::pwm_cnt_t'(launcher_pkg::PWM_MIN_OFF));

	//////////////////////////////////////////////////////////////////////
	// Hysteretic pulse control on measured current only
	//////////////////////////////////////////////////////////////////////

	assign start_pulse = i_firing && !o_pwm && min_off_done && (i_i_out < thresh_lo);
	// Window close cuts a pulse short
	assign end_pulse = o_pwm && (!i_firing || max_on_done ||
		(min_on_done && i_i_out > thresh_hi));

	always_ff @(posedge clk) begin
		if (reset) begin
			o_pwm <= 1'b0;
			on_cnt <= '0;
			off_cnt <= '0;
		end else if (start_pulse) begin
			o_pwm <= 1'b1;
			on_cnt <= launcher_pkg::pwm_cnt_t'(1);  // First high cycle
		end else if (end_pulse) begin
			o_pwm <= 1'b0;
			on_cnt <= '0;
			off_cnt <= launcher_pkg::pwm_cnt_t'(1); // First low cycle
		end else if (o_pwm) begin
			on_cnt <= on_cnt + 1'b1;
		end else if (!min_off_done) begin
			off_cnt <= off_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- logic/fire_debounce.sv
`timescale 1ns/100ps
`default_nettype none

module fire_debounce (
	input  logic clk,
	input  logic reset,
	input  logic i_button,  // Raw front panel button
	output logic o_pulse    // Fixed length, once per press
);

	logic [2:0] sync;   // Metastability chain
	logic btn;
	launcher_pkg::db_state_t state;
	launcher_pkg::db_state_t state_next;
	launcher_pkg::db_cnt_t press_cnt;    // Press qualify, then pulse length
	launcher_pkg::db_cnt_t release_cnt;  // Low time while waiting to re-arm
	logic press_done;
	logic pulse_done;
	logic release_done;

	always_ff @(posedge clk) begin
		if (reset) begin
			sync <= '0;
		end else begin
			sync <= {sync[1:0], i_button};
		end
	end

	assign btn = sync[2];

	// Idle cycle counts as the first press cycle
	assign press_done = (press_cnt == launcher_pkg::db_cnt_t'(launcher_pkg::DB_PRESS_CYCLES - 2));
	assign pulse_done = (press_cnt == launcher_pkg::db_cnt_t'(launcher_pkg::DB_PULSE_CYCLES - 1));
	assign release_done =
		(release_cnt == launcher_pkg::db_cnt_t'(launcher_pkg::DB_RELEASE_CYCLES - 1));

	always_comb begin
		state_next = state;
		case (state)
			launcher_pkg::DB_IDLE:    if (btn) state_next = launcher_pkg::DB_PRESS;
			launcher_pkg::DB_PRESS: begin
				if (!btn) state_next = launcher_pkg::DB_IDLE;   // Too short, no pulse
				else if (press_done) state_next = launcher_pkg::DB_PULSE;
			end
			launcher_pkg::DB_PULSE:   if (pulse_done) state_next = launcher_pkg::DB_HELD;
			launcher_pkg::DB_HELD:    if (!btn) state_next = launcher_pkg::DB_RELEASE;
			launcher_pkg::DB_RELEASE: begin
				if (btn) state_next = launcher_pkg::DB_HELD;    // Bounce, still the same press
				else if (release_done) state_next = launcher_pkg::DB_IDLE;
			end
			default:                  state_next = launcher_pkg::DB_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= launcher_pkg::DB_IDLE;
			press_cnt <= '0;
			release_cnt <= '0;
		end else begin
			state <= state_next;
			// Restart on every state change
			if (state_next == state && (state == launcher_pkg::DB_PRESS ||
				state == launcher_pkg::DB_PULSE)) begin
				press_cnt <= press_cnt + 1'b1;
			end else begin
				press_cnt <= '0;
			end
			release_cnt <= (state == launcher_pkg::DB_RELEASE) ? release_cnt + 1'b1 : '0;
		end
	end

	assign o_pulse = (state == launcher_pkg::DB_PULSE);

endmodule

`default_nettype wire

//--- logic/fire_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module fire_sequencer (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       i_fire_pulse,   // From debounce
	input  launcher_pkg::adc_samples_t i_samples,
	input  logic                       i_valid,
	input  logic                       i_charge_done,  // Charger reports full
	output logic                       o_firing,       // Current control window
	output logic                       o_high_set,     // Second setpoint step
	output logic                       o_dump,         // Discharge cap, held till reset
	output logic                       o_charge,       // Charger enable
	output logic                       o_arm_led
);

	launcher_pkg::fire_cnt_t fire_cnt;
	logic cap_charged;
	logic [launcher_pkg::BLINK_BITS-1:0] blink_cnt;

	//////////////////////////////////////////////////////////////////////
	// Fire counter and window, one shot per reset
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			fire_cnt <= '0;
			o_firing <= 1'b0;
			o_dump <= 1'b0;
		end else begin
			if (!o_dump && (fire_cnt != '0 || i_fire_pulse)) begin
				fire_cnt <= fire_cnt + 1'b1; // Frozen once dumped
			end
			if (fire_cnt == launcher_pkg::fire_cnt_t'(launcher_pkg::FIRE_START)) begin
				o_firing <= 1'b1;
			end else if (fire_cnt == launcher_pkg::fire_cnt_t'(launcher_pkg::FIRE_END)) begin
				o_firing <= 1'b0;
				o_dump <= 1'b1;  // Always dump after firing
			end
		end
	end

	assign o_high_set = o_firing &&
		(fire_cnt >= launcher_pkg::fire_cnt_t'(launcher_pkg::FIRE_STEP));

	// Auto charge from reset
	always_ff @(posedge clk) begin
		if (reset) begin
			o_charge <= 1'b1;
		end else if (i_charge_done || o_firing) begin
			o_charge <= 1'b0;
		end
	end

	// Arm hysteresis, 300 V on and 50 V off
	always_ff @(posedge clk) begin
		if (reset) begin
			cap_charged <= 1'b0;
			blink_cnt <= '0;
		end else begin
			blink_cnt <= blink_cnt + 1'b1;
			if (i_valid && i_samples.v_cap > launcher_pkg::ARM_ON_DN) cap_charged <= 1'b1;
			else if (i_valid && i_samples.v_cap < launcher_pkg::ARM_OFF_DN) cap_charged <= 1'b0;
		end
	end

	assign o_arm_led = cap_charged | (o_charge & blink_cnt[launcher_pkg::BLINK_BITS-1]);

endmodule

`default_nettype wire

//--- logic/launcher_top.sv
`timescale 1ns/100ps
`default_nettype none

module launcher_top (
	input  logic                       clk,
	input  logic                       reset,
	// Front panel and charger
	input  logic                       i_fire_button,
	input  logic                       i_charge_done,
	// Serial ADCs
	input  logic [1:0]                 i_ad_sdata_a,
	input  logic [1:0]                 i_ad_sdata_b,
	output logic                       o_ad_cs,
	// High voltage stage
	output logic                       o_pwm,
	output logic                       o_dump,
	output logic                       o_charge,
	output logic                       o_arm_led,
	// Monitor outputs
	output logic                       o_firing,
	output launcher_pkg::adc_samples_t o_samples,
	output logic                       o_sample_valid
);

	logic fire_pulse;
	logic high_set;

	adc_capture i_adc_capture (
		.clk(clk), .reset(reset), .i_sdata_a(i_ad_sdata_a), .i_sdata_b(i_ad_sdata_b),
		.o_ad_cs(o_ad_cs), .o_samples(o_samples), .o_valid(o_sample_valid)
	);

	fire_debounce i_fire_debounce (
		.clk(clk), .reset(reset), .i_button(i_fire_button), .o_pulse(fire_pulse)
	);

	fire_sequencer i_fire_sequencer (
		.clk(clk), .reset(reset), .i_fire_pulse(fire_pulse), .i_samples(o_samples),
		.i_valid(o_sample_valid), .i_charge_done(i_charge_done), .o_firing(o_firing),
		.o_high_set(high_set), .o_dump(o_dump), .o_charge(o_charge), .o_arm_led(o_arm_led)
	);

	current_regulator i_current_regulator (
		.clk(clk), .reset(reset), .i_firing(o_firing), .i_high_set(high_set),
		.i_i_out(o_samples.i_out), .o_pwm(o_pwm)
	);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run the testbench, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module launcher_tb -f sources.f \
	&& ./obj_dir/Vlauncher_tb > sim.log 2>&1 \
	|| { echo "Build or simulation run failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -qx "PASS: all tests" sim.log \
	&& echo "Simulation result: passed" \
	|| { echo "Simulation result: failed"; exit 1; }

//--- sources.f
common/launcher_pkg.sv
adc/adc_frame_timer.sv
adc/adc_channel_rx.sv
adc/adc_sample_decoder.sv
adc/adc_capture.sv
logic/fire_debounce.sv
logic/fire_sequencer.sv
logic/current_regulator.sv
logic/launcher_top.sv
verif/launcher_tb.sv

//--- verif/launcher_tb.sv
`timescale 1ns/100ps
`default_nettype none

module launcher_tb;

	localparam int RESET_CYCLES = 10;
	localparam int RANDOM_FRAMES = 40;
	localparam int WATCHDOG_CYCLES = 20000;   // About four times the summed test length
	localparam int BIAS [4] = '{5, 5, 5, 6};  // i_out v_cap v_aux v_out
	localparam launcher_pkg::adc_mag_t I_LOW = 11'd100;    // Below both start thresholds
	localparam launcher_pkg::adc_mag_t I_MID = 11'd600;    // Between the 2 A and 4 A bands
	localparam launcher_pkg::adc_mag_t I_HIGH = 11'd1000;  // Above both end thresholds

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic i_fire_button = 1'b0;
	logic i_charge_done = 1'b0;
	logic [1:0] i_ad_sdata_a = '0;
	logic [1:0] i_ad_sdata_b = '0;
	logic o_ad_cs;
	logic o_pwm;
	logic o_dump;
	logic o_charge;
	logic o_arm_led;
	logic o_firing;
	launcher_pkg::adc_samples_t o_samples;
	logic o_sample_valid;

	launcher_pkg::adc_raw_bank_t adc_word = '0;  // Words for the next frame
	launcher_pkg::adc_raw_bank_t frame_word;     // Words now on the serial lines
	int bit_pos = -1;                            // Next bit to drive, -1 when idle
	logic frame_seen = 1'b0;
	integer seed = 32'h4ffc_3fa9;
	int errors = 0;
	int checks = 0;
	int base_errors = 0;                         // Errors before the current test
	int sample_checks = 0;
	int fire_len = 0;                            // Cycles with o_firing high
	int on_len = 0;
	int gap_len = 0;
	int n_max = 0;                               // Full length pulses
	int n_short = 0;                             // Pulses ended by high current
	int max_before = 0;                          // Full length pulses before the 4 A step
	logic high_phase = 1'b0;                     // Past the setpoint step
	launcher_pkg::adc_mag_t set_dn;              // Setpoint expected in the regulator
	logic pwm_q = 1'b0;
	logic firing_q = 1'b0;
	launcher_pkg::adc_mag_t iout_q = '0;         // i_out seen by the regulator last cycle

	always #20 clk = ~clk;  // 25 MHz

	assign set_dn = high_phase ? launcher_pkg::SET_HI_DN : launcher_pkg::SET_LO_DN;

	launcher_top i_launcher_top (
		.clk(clk), .reset(reset), .i_fire_button(i_fire_button), .i_charge_done(i_charge_done),
		.i_ad_sdata_a(i_ad_sdata_a), .i_ad_sdata_b(i_ad_sdata_b), .o_ad_cs(o_ad_cs),
		.o_pwm(o_pwm), .o_dump(o_dump), .o_charge(o_charge), .o_arm_led(o_arm_led),
		.o_firing(o_firing), .o_samples(o_samples), .o_sample_valid(o_sample_valid)
	);

	//////////////////////////////////////////////////////////////////////
	// Reference model and compare tasks
	//////////////////////////////////////////////////////////////////////

	// Bias add, negative clips to zero, else low 11 bits inverted
	function automatic launcher_pkg::adc_samples_t adc_expect(
		input launcher_pkg::adc_raw_bank_t raw);
		launcher_pkg::adc_mag_t mag [4];
		logic [11:0] corr;
		launcher_pkg::adc_samples_t res;
		for (int ch = 0; ch < 4; ch++) begin
			corr = raw[ch] + 12'(BIAS[ch]);
			mag[ch] = corr[11] ? '0 : ~corr[10:0];
		end
		res.i_out = mag[0];
		res.v_cap = mag[1];
		res.v_aux = mag[2];
		res.v_out = mag[3];
		return res;
	endfunction

	function automatic launcher_pkg::adc_raw_t raw_for_mag(input launcher_pkg::adc_mag_t mag,
		input int ch);
		raw_for_mag = {1'b0, ~mag} - 12'(BIAS[ch]);  // Inverse of the decode rule
	endfunction

	function automatic launcher_pkg::adc_raw_t random_word();
		logic [31:0] r;
		r = $random(seed);
		// One in four lands near zero, straddling the sign after bias
		random_word = (r[13:12] == 2'd0) ? 12'h7f8 + 12'(r[3:0]) : r[11:0];
	endfunction

	task automatic check_samples(input launcher_pkg::adc_samples_t got,
		input launcher_pkg::adc_samples_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: samples %0d %0d %0d %0d, expected %0d %0d %0d %0d", $time,
				got.i_out, got.v_cap, got.v_aux, got.v_out,
				exp.i_out, exp.v_cap, exp.v_aux, exp.v_out);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string name);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input int got, input int exp, input string name);
		checks++;
		if (got != exp) begin
			errors++;
			$display("MISMATCH at %0t: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("ERROR at %0t: %s", $time, msg);
	endtask

	task automatic finish_test(input string name);
		$display("test %s done, %0d errors", name, errors - base_errors);
		base_errors = errors;
	endtask

	// Returns on the edge that samples the n-th strobe
	task automatic wait_frames(input int n);
		repeat (n) begin
			@(posedge clk);
			while (!o_sample_valid) @(posedge clk);
		end
	endtask

	task automatic set_mag(input int ch, input launcher_pkg::adc_mag_t mag);
		adc_word[ch] <= raw_for_mag(mag, ch);
	endtask

	task automatic check_arm(input launcher_pkg::adc_mag_t v_cap, input logic exp,
		input string name);
		set_mag(1, v_cap);
		wait_frames(2);   // Second strobe always carries the new word
		@(posedge clk);   // LED follows the strobe edge
		check_bit(o_arm_led, exp, name);
	endtask

	//////////////////////////////////////////////////////////////////////
	// ADC model, sample compare and PWM monitor
	//////////////////////////////////////////////////////////////////////

	// MSB goes out in the cycle after cs, one bit per cycle after that
	always @(posedge clk) begin
		if (o_ad_cs) begin
			frame_word <= adc_word;
			frame_seen <= 1'b1;
			bit_pos <= launcher_pkg::ADC_BITS - 2;
			i_ad_sdata_a <= {adc_word[1][11], adc_word[0][11]};
			i_ad_sdata_b <= {adc_word[3][11], adc_word[2][11]};
		end else if (bit_pos >= 0) begin
			bit_pos <= bit_pos - 1;
			i_ad_sdata_a <= {frame_word[1][bit_pos], frame_word[0][bit_pos]};
			i_ad_sdata_b <= {frame_word[3][bit_pos], frame_word[2][bit_pos]};
		end
	end

	always @(posedge clk) begin
		if (!reset && o_sample_valid && frame_seen) begin  // Skip the frame before first cs
			sample_checks <= sample_checks + 1;
			check_samples(o_samples, adc_expect(frame_word));
		end
	end

	always @(posedge clk) begin
		if (!reset) begin
			if (o_firing) fire_len <= fire_len + 1;
			if (o_pwm && !pwm_q) begin  // Pulse began on the last edge
				if (iout_q >= set_dn - launcher_pkg::SET_BAND_DN)
					report_error("PWM pulse started with i_out not below band");
				if (gap_len < launcher_pkg::PWM_MIN_OFF) report_error("PWM off gap too short");
				on_len <= 1;
			end else if (o_pwm) begin
				on_len <= on_len + 1;
			end
			if (!o_pwm && pwm_q) begin
				if (firing_q) begin  // Cuts at window close not judged
					if (on_len < launcher_pkg::PWM_MIN_ON || on_len > launcher_pkg::PWM_MAX_ON)
						report_error("PWM pulse length out of range");
					if (on_len != launcher_pkg::PWM_MAX_ON &&
						iout_q <= set_dn + launcher_pkg::SET_BAND_DN)
						report_error("PWM pulse ended early with i_out not above band");
					if (on_len == launcher_pkg::PWM_MAX_ON) n_max <= n_max + 1;
					else n_short <= n_short + 1;
				end
				gap_len <= 1;
			end else if (!o_pwm) begin
				gap_len <= gap_len + 1;
			end
			if (o_pwm && !o_firing && !firing_q) report_error("o_pwm high outside firing window");
			pwm_q <= o_pwm;
			firing_q <= o_firing;
			iout_q <= o_samples.i_out;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("ERROR: watchdog expired after %0d cycles, a wait never ended", WATCHDOG_CYCLES);
		$display("FAIL: see errors above");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////////////////////////

	initial begin
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;

		// New random words every frame
		for (int n = 0; n < RANDOM_FRAMES; n++) begin
			wait_frames(1);
			for (int ch = 0; ch < 4; ch++) adc_word[ch] <= random_word();
		end
		wait_frames(2);
		if (sample_checks < RANDOM_FRAMES) report_error("too few sample strobes seen");
		finish_test("adc_random");

		i_fire_button <= 1'b1;
		repeat (launcher_pkg::DB_PRESS_CYCLES - 20) @(posedge clk);
		i_fire_button <= 1'b0;
		repeat (2 * launcher_pkg::DB_RELEASE_CYCLES) begin
			@(posedge clk);
			check_bit(o_firing, 1'b0, "o_firing after short press");
		end
		finish_test("short_press");

		check_bit(o_charge, 1'b1, "o_charge before charge done");
		i_charge_done <= 1'b1;  // Charger done, blink stops
		repeat (3) @(posedge clk);
		check_bit(o_charge, 1'b0, "o_charge after charge done");
		check_arm(launcher_pkg::ARM_ON_DN + 11'd100, 1'b1, "o_arm_led above on level");
		check_arm(11'd872, 1'b1, "o_arm_led between levels");
		check_arm(launcher_pkg::ARM_OFF_DN - 11'd100, 1'b0, "o_arm_led below off level");
		finish_test("arm_hysteresis");

		set_mag(0, I_LOW);
		wait_frames(2);
		i_fire_button <= 1'b1;
		while (!o_firing) @(posedge clk);
		i_fire_button <= 1'b0;
		check_bit(o_dump, 1'b0, "o_dump during firing");
		wait_frames(60);      // Low current, full length pulses
		for (int k = 0; k < 60; k++) begin
			wait_frames(1);
			set_mag(0, k[0] ? I_HIGH : I_LOW);  // Current crosses the band each frame
		end
		wait_frames(1);
		set_mag(0, I_HIGH);   // No new pulse until the 4 A step
		while (fire_len < launcher_pkg::FIRE_STEP + 100) @(posedge clk);
		high_phase <= 1'b1;
		max_before = n_max;
		set_mag(0, I_MID);    // Starts pulses only on the 4 A setpoint
		while (o_firing) @(posedge clk);
		check_count(fire_len, launcher_pkg::FIRE_END - launcher_pkg::FIRE_START, "firing cycles");
		check_bit(o_dump, 1'b1, "o_dump at window end");
		check_bit(o_charge, 1'b0, "o_charge after firing");
		repeat (200) @(posedge clk);
		check_bit(o_dump, 1'b1, "o_dump held after window");
		if (n_max == 0 || n_short == 0) report_error("missing full length or early ended pulses");
		if (n_max == max_before) report_error("no PWM pulses on the high setpoint");
		finish_test("fire_window_and_pwm");

		$display("tests 4, checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire
